//--- cube_scan.f
+incdir+hdl
+incdir+tests
hdl/cube_geom_pkg.sv
hdl/hc595_pkg.sv
hdl/scan_tick_gen.sv
hdl/layer_sequencer.sv
hdl/hc595_shifter.sv
hdl/cube_scan.sv
tests/tb_cube_scan.sv

//--- tests/tb_cube_scan_checks.svh
`ifndef TB_CUBE_SCAN_CHECKS_SVH
`define TB_CUBE_SCAN_CHECKS_SVH

// Error counts, one per kind of result
int frame_errors = 0;
int cycle_errors = 0;
int pin_errors   = 0;
int checks_run   = 0;

// Whole 72-bit frame as seen at the chain outputs
task automatic check_frame(
    input string        name,
    input hc595_frame_t expected,
    input hc595_frame_t actual
);
    checks_run++;
    if (actual !== expected) begin
        frame_errors++;
        $display("Mismatch at %0t: %s expected sel %b pix %h, actual sel %b pix %h",
                 $realtime, name, expected.layer_sel, expected.pixels,
                 actual.layer_sel, actual.pixels);
    end
endtask

// Cycle spacing or edge counts
task automatic check_cycles(input string name, input integer expected, input integer actual);
    checks_run++;
    if (actual !== expected) begin
        cycle_errors++;
        $display("Mismatch at %0t: %s expected %0d, actual %0d",
                 $realtime, name, expected, actual);
    end
endtask

// Pin levels on the chain interface
task automatic check_pins(input string name, input hc595_pins_t expected,
                          input hc595_pins_t actual);
    checks_run++;
    if (actual !== expected) begin
        pin_errors++;
        $display("Mismatch at %0t: %s expected %b, actual %b",
                 $realtime, name, expected, actual);
    end
endtask

`endif

//--- tests/tb_cube_scan.sv
`include "cube_scan_defines.svh"

module tb_cube_scan
    import cube_geom_pkg::*;
    import hc595_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    `include "tb_cube_scan_checks.svh"

    localparam int TB_CLK_DIV  = 4;
    localparam int CLK_PERIOD  = 10;
    localparam int NUM_ENTRIES = 4;
    localparam int SCLK_GAP    = 2 * TB_CLK_DIV;     // Cycles between shift edges
    localparam longint WATCHDOG_NS = longint'(NUM_ENTRIES + 1) * `CUBE_LAYERS
                                     * `HC595_STEPS * TB_CLK_DIV * CLK_PERIOD * 2;

    typedef struct {
        string        name;
        cube_t        pixels;
        hc595_frame_t exp_frame [`CUBE_LAYERS];      // Expected latch per layer
    } stim_entry_t;

    logic        clk_in;
    logic        rst_n_in;
    cube_t       cube;
    hc595_pins_t pins;

    stim_entry_t stim_table [NUM_ENTRIES];
    int          cur_entry;
    logic        skip_pending;     // Next latch holds a frame loaded before the change
    int          frames_checked;

    // Chain model state
    logic [`CUBE_FRAME_BITS-1:0] chain;
    hc595_frame_t                latched;
    hc595_pins_t                 prev_pins;
    longint                      cycle;
    longint                      last_sclk;
    int                          sclk_edges;
    layer_idx_t                  exp_layer;

    cube_scan #(
        .CLK_DIV  (TB_CLK_DIV)
    ) dut (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .cube     (cube),
        .pins     (pins)
    );

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    function automatic void build_table();
        logic [15:0] lfsr;
        cube_t       walk;
        cube_t       rnd;
        lfsr = 16'd39;
        for (int l = 0; l < `CUBE_LAYERS; l++) begin
            walk[l] = layer_t'(64'hFF) << (8 * l);    // Row l lit on layer l
            for (int b = 0; b < `CUBE_LAYER_BITS; b++) begin
                lfsr      = lfsr_next(lfsr);
                rnd[l][b] = lfsr[0];
            end
        end
        stim_table[0].name   = "zeros";
        stim_table[0].pixels = '0;
        stim_table[1].name   = "ones";
        stim_table[1].pixels = '1;
        stim_table[2].name   = "walking";
        stim_table[2].pixels = walk;
        stim_table[3].name   = "lfsr";
        stim_table[3].pixels = rnd;
        // One-hot select above the pixels of that layer
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            for (int l = 0; l < `CUBE_LAYERS; l++) begin
                stim_table[e].exp_frame[l].layer_sel    = '0;
                stim_table[e].exp_frame[l].layer_sel[l] = 1'b1;
                stim_table[e].exp_frame[l].pixels       = stim_table[e].pixels[l];
            end
        end
    endfunction

    // ------------------------------------------------------------------------
    // 595 chain model, sampled on the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk_in) begin
        cycle++;
        if (pins.sclk && !prev_pins.sclk) begin
            chain = {chain[`CUBE_FRAME_BITS-2:0], pins.sdio};
            if (sclk_edges > 0) begin
                check_cycles("sclk spacing", SCLK_GAP, int'(cycle - last_sclk));
            end
            last_sclk = cycle;
            sclk_edges++;
        end
        if (pins.rclk && !prev_pins.rclk) begin
            latched = chain;
            check_cycles("sclk edges per frame", `CUBE_FRAME_BITS, sclk_edges);
            sclk_edges = 0;
            if (skip_pending) begin
                skip_pending = 1'b0;                     // In flight at the change
            end else begin
                check_frame("latched frame", stim_table[cur_entry].exp_frame[exp_layer],
                            latched);
                frames_checked++;
            end
            exp_layer = exp_layer - 1'b1;                // 7 down to 0, then wrap
        end
        prev_pins = pins;
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        $timeformat(-9, 1, " ns", 0);
        clk_in         = 1'b0;
        rst_n_in       = 1'b0;
        cube           = '0;
        cur_entry      = 0;
        skip_pending   = 1'b1;
        frames_checked = 0;
        chain          = '0;
        prev_pins      = '0;
        cycle          = 0;
        last_sclk      = 0;
        sclk_edges     = 0;
        exp_layer      = layer_idx_t'(`CUBE_LAYERS - 1);
        build_table();

        repeat (2) @(posedge clk_in);
        #1 rst_n_in = 1'b1;

        // Quiet pins until the first tick
        repeat (TB_CLK_DIV) begin
            @(negedge clk_in);
            check_pins("pins after reset", '0, pins);
        end

        for (int e = 0; e < NUM_ENTRIES; e++) begin
            int target;
            @(posedge clk_in);
            #1;
            cube         = stim_table[e].pixels;
            cur_entry    = e;
            // While rclk is high the frame in flight is already latched
            skip_pending = !pins.rclk;
            target       = frames_checked + `CUBE_LAYERS;
            wait (frames_checked >= target);             // One full scan on the new cube
        end

        $display("Errors: %0d frame, %0d cycle, %0d pin, in %0d checks",
                 frame_errors, cycle_errors, pin_errors, checks_run);
        if (frame_errors + cycle_errors + pin_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the scan did not finish all %0d patterns within %0d ns",
                 NUM_ENTRIES, WATCHDOG_NS);
        $display("Errors: %0d frame, %0d cycle, %0d pin, in %0d checks",
                 frame_errors, cycle_errors, pin_errors, checks_run);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- hdl/cube_scan.sv
`include "cube_scan_defines.svh"

module cube_scan
    import cube_geom_pkg::*;
    import hc595_pkg::*;
#(
    parameter int CLK_DIV = `CUBE_CLK_DIV      // System clocks per serial step
) (
    input  logic        clk_in,
    input  logic        rst_n_in,
    input  cube_t       cube,
    output hc595_pins_t pins
);

    // --------------------------------------------------------------------------
    // Internal wiring
    // --------------------------------------------------------------------------
    logic         tick;       // Serial step enable
    logic         load;       // Sequencer to shifter, frame valid
    logic         busy;       // Shifter occupied
    logic         done;       // Frame latched into the chain
    hc595_frame_t frame;

    // Serial rate
    scan_tick_gen #(
        .DIV      (CLK_DIV)
    ) u_tick_gen (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .tick     (tick)
    );

    // Layer order and frame assembly
    layer_sequencer u_sequencer (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .cube     (cube),
        .busy     (busy),
        .done     (done),
        .load     (load),
        .frame    (frame)
    );

    // 595 chain protocol
    hc595_shifter u_shifter (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .tick     (tick),
        .load     (load),
        .frame    (frame),
        .busy     (busy),
        .done     (done),
        .pins     (pins)
    );

endmodule

//--- hdl/hc595_shifter.sv
`include "cube_scan_defines.svh"

module hc595_shifter
    import hc595_pkg::*;
(
    input  logic         clk_in,
    input  logic         rst_n_in,
    input  logic         tick,
    input  logic         load,
    input  hc595_frame_t frame,
    output logic         busy,
    output logic         done,
    output hc595_pins_t  pins
);

    localparam int BIT_W = $clog2(`CUBE_FRAME_BITS);

    // Step numbers of the latch phase
    localparam hc595_step_t RCLK_HI_STEP = hc595_step_t'(`HC595_STEPS - 2);
    localparam hc595_step_t LAST_STEP    = hc595_step_t'(`HC595_STEPS - 1);
    localparam logic [BIT_W-1:0] MSB_POS = BIT_W'(`CUBE_FRAME_BITS - 1);

    hc595_frame_t                 frame_q;      // Frame being shifted
    logic [`CUBE_FRAME_BITS-1:0]  frame_bits;
    hc595_step_t                  step;
    logic [BIT_W-1:0]             bit_pos;
    logic                         adv;

    assign frame_bits = frame_q;
    assign adv        = busy && tick;           // One step per tick

    // Step 2j sends bit 71-j, so the frame goes out MSB first
    assign bit_pos = MSB_POS - BIT_W'(step >> 1);

    // --------------------------------------------------------------------------
    // Frame capture
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_in) begin
        if (load) begin
            frame_q <= frame;
        end
    end

    // --------------------------------------------------------------------------
    // Step counter and handshake
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            done <= 1'b0;
            if (load) begin
                busy <= 1'b1;                   // Visible the cycle after load
                step <= '0;
            end else if (adv) begin
                if (step == LAST_STEP) begin
                    busy <= 1'b0;
                    done <= 1'b1;               // Same cycle busy falls
                    step <= '0;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------------------------------
    // Serial pins
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            pins <= '0;
        end else if (adv) begin
            if (step < RCLK_HI_STEP) begin
                if (!step[0]) begin
                    pins.sclk <= 1'b0;          // Data changes on the low phase
                    pins.sdio <= frame_bits[bit_pos];
                end else begin
                    pins.sclk <= 1'b1;          // 595 shifts here
                end
            end else if (step == RCLK_HI_STEP) begin
                pins.rclk <= 1'b1;              // Whole chain to the outputs
            end else begin
                pins.rclk <= 1'b0;
            end
        end
    end

    // --------------------------------------------------------------------------
    // Checks
    // --------------------------------------------------------------------------
    // Latch pulse sits apart from any shift edge
    a_rclk_quiet: assert property (
        @(posedge clk_in) disable iff (!rst_n_in)
        $changed(pins.sclk) |-> !pins.rclk && !$past(pins.rclk)
    );

    a_step_range: assert property (
        @(posedge clk_in) disable iff (!rst_n_in)
        step <= LAST_STEP
    );

endmodule

//--- hdl/layer_sequencer.sv
`include "cube_scan_defines.svh"

module layer_sequencer
    import cube_geom_pkg::*;
    import hc595_pkg::*;
(
    input  logic         clk_in,
    input  logic         rst_n_in,
    input  cube_t        cube,
    input  logic         busy,
    input  logic         done,
    output logic         load,
    output hc595_frame_t frame
);

    layer_idx_t layer_idx;      // Layer of the frame last loaded
    layer_idx_t next_idx;
    layer_sel_t next_sel;
    logic       start_pend;     // First load after reset still owed
    logic       issue;

    // --------------------------------------------------------------------------
    // Next layer
    // --------------------------------------------------------------------------
    // Scan runs downward and wraps 0 -> 7 by plain overflow.
    // layer_idx resets to 0 so the first frame comes out for layer 7.
    assign next_idx = layer_idx - 1'b1;
    assign next_sel = layer_sel_t'(1) << next_idx;
    assign issue    = start_pend || done;

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            start_pend <= 1'b1;
            layer_idx  <= '0;
            load       <= 1'b0;
        end else begin
            load <= 1'b0;                       // Strobe by default
            if (issue) begin
                start_pend <= 1'b0;
                layer_idx  <= next_idx;
                load       <= 1'b1;
            end
        end
    end

    // Frame payload, valid from the first load onward
    always_ff @(posedge clk_in) begin
        if (issue) begin
            frame.layer_sel <= next_sel;
            frame.pixels    <= cube[next_idx];  // Cube sampled here
        end
    end

    // --------------------------------------------------------------------------
    // Checks
    // --------------------------------------------------------------------------
    // Shifter has no queue, a load must find it idle
    a_load_idle: assert property (
        @(posedge clk_in) disable iff (!rst_n_in)
        load |-> !busy
    );

    // Exactly one layer driven once scanning has begun
    a_sel_onehot: assert property (
        @(posedge clk_in) disable iff (!rst_n_in)
        !start_pend |-> $onehot(frame.layer_sel)
    );

endmodule

//--- hdl/scan_tick_gen.sv
`include "cube_scan_defines.svh"

module scan_tick_gen #(
    parameter int DIV = `CUBE_CLK_DIV
) (
    input  logic clk_in,
    input  logic rst_n_in,
    output logic tick
);

    // Counter wide enough for DIV-1, at least one bit
    localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DIV - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= (cnt == CNT_MAX);       // Registered, first pulse DIV clocks after reset
            if (cnt == CNT_MAX) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // --------------------------------------------------------------------------
    // Checks
    // --------------------------------------------------------------------------
    generate
        if (DIV > 1) begin : g_tick_check
            // A tick is a single-cycle enable, never a level
            a_tick_single: assert property (
                @(posedge clk_in) disable iff (!rst_n_in)
                tick |=> !tick
            );
        end
    endgenerate

endmodule

//--- hdl/hc595_pkg.sv
`include "cube_scan_defines.svh"

// Types for the 74HC595 chain and its serial protocol
package hc595_pkg;

    import cube_geom_pkg::*;

    // --------------------------------------------------------------------------
    // Frame shifted into the chain, MSB first
    // --------------------------------------------------------------------------
    typedef struct packed {
        layer_sel_t layer_sel;    // Lands in the last 595 of the chain
        layer_t     pixels;       // Column drivers
    } hc595_frame_t;

    // --------------------------------------------------------------------------
    // Pins toward the chain
    // --------------------------------------------------------------------------
    typedef struct packed {
        logic sclk;               // SRCLK, shift on rising edge
        logic rclk;               // RCLK, latch on rising edge
        logic sdio;               // SER data
    } hc595_pins_t;

    // Serial step within one frame, 0 to HC595_STEPS-1
    typedef logic [$clog2(`HC595_STEPS)-1:0] hc595_step_t;

endpackage

//--- hdl/cube_geom_pkg.sv
`include "cube_scan_defines.svh"

// Types that describe the cube itself, independent of how it is driven
package cube_geom_pkg;

    // Pixel bits of one horizontal layer
    typedef logic [`CUBE_LAYER_BITS-1:0] layer_t;

    // Whole cube, layer 0 is the bottom layer of the chain's select byte
    typedef layer_t [`CUBE_LAYERS-1:0] cube_t;

    // Layer number, 0 to CUBE_LAYERS-1
    typedef logic [$clog2(`CUBE_LAYERS)-1:0] layer_idx_t;

    // One bit per layer, exactly one set while scanning
    typedef logic [`CUBE_LAYERS-1:0] layer_sel_t;

endpackage

//--- hdl/cube_scan_defines.svh
`ifndef CUBE_SCAN_DEFINES_SVH
`define CUBE_SCAN_DEFINES_SVH

// --------------------------------------------------------------------------
// Cube geometry
// --------------------------------------------------------------------------
`define CUBE_LAYERS      8            // Layers, one select bit each
`define CUBE_LAYER_BITS  64           // Pixels per layer, 8 x 8

// One-hot select byte above the pixel bits
`define CUBE_FRAME_BITS  (`CUBE_LAYERS + `CUBE_LAYER_BITS)

// --------------------------------------------------------------------------
// Serial timing
// --------------------------------------------------------------------------
`define CUBE_CLK_DIV     50           // System clocks per serial step

// Two steps per bit, then rclk high and rclk low
`define HC595_STEPS      (2 * `CUBE_FRAME_BITS + 2)

`endif
